// ==== common/mem_req_if.sv ====
// mem_req_if: arbitrated request channel between arbitration tree and bank, with modports
interface mem_req_if import scratch_pkg::*; #(
  // width of the requester index, derived from the requester count by the user
  parameter int unsigned IdxWidth = $clog2(NumReqDefault)
);

  // the arbiter has a winner and presents it to the bank
  logic                req;

  // the bank can take the request in this cycle
  logic                gnt;

  // operation, address and write data of the winner
  mem_req_t            payload;

  // which requester the payload belongs to
  logic [IdxWidth-1:0] idx;

  // arbiter side drives the request and waits for the grant
  modport arb (
    output req,
    output payload,
    output idx,
    input  gnt
  );

  // bank side samples the request and decides the grant
  modport bank (
    input  req,
    input  payload,
    input  idx,
    output gnt
  );

endinterface

// ==== common/scratch_pkg.sv ====
// scratch_pkg: default sizes, opcode and bank state enums, request payload struct
package scratch_pkg;

  //////////////////////////////
  // default sizes
  //////////////////////////////

  // number of requesters sharing the bank unless the top level overrides it
  localparam int unsigned NumReqDefault = 4;

  // word address into the bank, 32 words deep
  localparam int unsigned AddrWidth = 5;

  // width of one stored word and of the read response
  localparam int unsigned DataWidth = 32;

  //////////////////////////////
  // enums
  //////////////////////////////

  // operation carried with each request
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // bank either takes a request or sits out the cycle after a write
  typedef enum logic {
    BANK_IDLE = 1'b0,
    BANK_TURN = 1'b1
  } bank_state_e;

  //////////////////////////////
  // payload
  //////////////////////////////

  // one request as it travels through the arbitration tree
  // wdata is ignored by the bank on reads
  typedef struct packed {
    mem_op_e                op;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
  } mem_req_t;

endpackage

// ==== design/lzc.sv ====
// lzc: trailing or leading zero counter built as a reduction tree, with an empty flag
module lzc #(
  // number of input bits
  parameter int unsigned Width = 4,
  // 0 counts from the low end (trailing zeros), 1 from the high end (leading zeros)
  parameter bit          Mode  = 1'b0,
  localparam int unsigned CntWidth = (Width > 1) ? $clog2(Width) : 1
) (
  input  logic [Width-1:0]    in_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                empty_o
);

  if (Width == 1) begin : gen_single
    // a single bit has no zeros to count before it
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];
  end else begin : gen_tree
    localparam int unsigned NumLevels = $clog2(Width);
    localparam int unsigned NumNodes  = 2**NumLevels - 1;

    // input in search order, so the tree always looks for the lowest set bit
    logic [Width-1:0]                   in_ord;
    // a node sees at least one set bit below it
    logic [NumNodes-1:0]                vld_nodes;
    // position of the first set bit below a node
    logic [NumNodes-1:0][CntWidth-1:0]  pos_nodes;

    for (genvar i = 0; i < Width; i++) begin : gen_order
      assign in_ord[i] = Mode ? in_i[Width-1-i] : in_i[i];
    end

    for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
      for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
        localparam int unsigned Node  = 2**level - 1 + l;
        localparam int unsigned Child = 2**(level+1) - 1 + l*2;

        if (level == NumLevels-1) begin : gen_leaf
          // leaves look at two neighbouring input bits
          if (l*2 < Width-1) begin : gen_pair
            assign vld_nodes[Node] = in_ord[l*2] | in_ord[l*2+1];
            assign pos_nodes[Node] = in_ord[l*2] ? CntWidth'(l*2) : CntWidth'(l*2+1);
          end else if (l*2 == Width-1) begin : gen_odd
            assign vld_nodes[Node] = in_ord[l*2];
            assign pos_nodes[Node] = CntWidth'(l*2);
          end else begin : gen_pad
            // padding leaves beyond the input width never win
            assign vld_nodes[Node] = 1'b0;
            assign pos_nodes[Node] = '0;
          end
        end else begin : gen_inner
          // the lower half wins whenever it holds a set bit
          assign vld_nodes[Node] = vld_nodes[Child] | vld_nodes[Child+1];
          assign pos_nodes[Node] = vld_nodes[Child] ? pos_nodes[Child] : pos_nodes[Child+1];
        end
      end
    end

    // root of the tree holds the answer for the whole vector
    assign cnt_o   = pos_nodes[0];
    assign empty_o = ~vld_nodes[0];
  end

endmodule

// ==== design/scratch_arb_top.sv ====
// scratch_arb_top: four-port scratchpad top joining arbitration tree and bank
module scratch_arb_top import scratch_pkg::*; #(
  // number of requester ports
  parameter int unsigned NumReq  = NumReqDefault,
  // fair priority update in the arbiter
  parameter bit          FairArb = 1'b1,
  // hold the arbiter decision while the bank stalls
  parameter bit          LockIn  = 1'b1,
  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // one entry per requester, each held until its grant
  input  logic    [NumReq-1:0]                 req_i,
  input  mem_op_e [NumReq-1:0]                 op_i,
  input  logic    [NumReq-1:0][AddrWidth-1:0]  addr_i,
  input  logic    [NumReq-1:0][DataWidth-1:0]  wdata_i,
  output logic    [NumReq-1:0]                 gnt_o,
  // shared read response, tagged with the requester index
  output logic                              rvalid_o,
  output logic [IdxWidth-1:0]               rid_o,
  output logic [DataWidth-1:0]              rdata_o
);

  // per requester payload as the tree multiplexes it
  mem_req_t [NumReq-1:0] req_data;

  for (genvar i = 0; i < NumReq; i++) begin : gen_pack
    assign req_data[i] = '{op: op_i[i], addr: addr_i[i], wdata: wdata_i[i]};
  end

  // winner of the arbitration on its way to the bank
  mem_req_if #(
    .IdxWidth (IdxWidth)
  ) arb_if ();

  rr_arb_tree #(
    .NumIn   (NumReq),
    .FairArb (FairArb),
    .LockIn  (LockIn)
  ) i_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (req_i),
    .gnt_o   (gnt_o),
    .data_i  (req_data),
    .arb_o   (arb_if.arb)
  );

  scratch_bank #(
    .NumReq (NumReq)
  ) i_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_if   (arb_if.bank),
    .rvalid_o (rvalid_o),
    .rid_o    (rid_o),
    .rdata_o  (rdata_o)
  );

endmodule

// ==== design/scratch_bank.sv ====
// scratch_bank: single-port register array with write turnaround stall and tagged read response
module scratch_bank import scratch_pkg::*; #(
  // requester count, sets the width of the response tag
  parameter int unsigned NumReq = NumReqDefault,
  // number of stored words
  parameter int unsigned Depth  = 2**AddrWidth,
  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  mem_req_if.bank              req_if,
  output logic                 rvalid_o,
  output logic [IdxWidth-1:0]  rid_o,
  output logic [DataWidth-1:0] rdata_o
);

  // storage, contents are undefined until written
  logic [DataWidth-1:0] mem_q [Depth];

  bank_state_e          state_q;
  bank_state_e          state_d;

  // request taken on this edge, split by operation
  logic                 accept;
  logic                 wr_accept;
  logic                 rd_accept;

  logic                 rvalid_q;
  logic [IdxWidth-1:0]  rid_q;
  logic [DataWidth-1:0] rdata_q;

  //////////////////////////////
  // grant and stall
  //////////////////////////////

  // the bank only takes requests when it is not turning around after a write
  assign req_if.gnt = (state_q == BANK_IDLE);

  assign accept    = req_if.req & req_if.gnt;
  assign wr_accept = accept & (req_if.payload.op == OP_WRITE);
  assign rd_accept = accept & (req_if.payload.op == OP_READ);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BANK_IDLE: begin
        // every write costs one extra cycle before the next request
        if (wr_accept) begin
          state_d = BANK_TURN;
        end
      end
      BANK_TURN: begin
        state_d = BANK_IDLE;
      end
      default: begin
        state_d = BANK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= BANK_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // response appears for exactly one cycle after each accepted read
      rvalid_q <= rd_accept;
    end
  end

  //////////////////////////////
  // storage and response
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem_q[req_if.payload.addr] <= req_if.payload.wdata;
    end
  end

  // tag and data only change on a read, so they hold the last response otherwise
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rid_q   <= req_if.idx;
      rdata_q <= mem_q[req_if.payload.addr];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rid_o    = rid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== rr_arb_tree/rr_arb_tree.sv ====
// rr_arb_tree: round-robin arbitration tree with fair or rotating priority, lock-in and flush
module rr_arb_tree import scratch_pkg::*; #(
  // number of requesters
  parameter int unsigned NumIn   = NumReqDefault,
  // jump the priority to the next waiting requester instead of counting up by one
  parameter bit          FairArb = 1'b1,
  // hold the decision while the bank withholds its grant
  parameter bit          LockIn  = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic     [NumIn-1:0] req_i,
  output logic     [NumIn-1:0] gnt_o,
  input  mem_req_t [NumIn-1:0] data_i,
  mem_req_if.arb               arb_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  if (NumIn == 1) begin : gen_pass_through
    // nothing to arbitrate, the only requester talks to the bank directly
    assign arb_o.req     = req_i[0];
    assign arb_o.payload = data_i[0];
    assign arb_o.idx     = '0;
    assign gnt_o[0]      = arb_o.gnt;
  end else begin : gen_arbiter
    localparam int unsigned NumLevels = $clog2(NumIn);
    localparam int unsigned NumNodes  = 2**NumLevels - 1;

    // node zero is the root, children of node n sit at 2n+1 and 2n+2
    logic     [NumNodes-1:0]               req_nodes;
    logic     [NumNodes-1:0]               gnt_nodes;
    logic     [NumNodes-1:0][IdxWidth-1:0] idx_nodes;
    mem_req_t [NumNodes-1:0]               data_nodes;

    // highest priority requester and its next value
    logic [IdxWidth-1:0] rr_q;
    logic [IdxWidth-1:0] rr_d;

    // request set the tree actually works on, live or frozen
    logic [NumIn-1:0]    req_d;

    // a transfer to the bank completes on this edge
    logic                accept;

    assign arb_o.req     = req_nodes[0];
    assign arb_o.payload = data_nodes[0];
    assign arb_o.idx     = idx_nodes[0];
    assign accept        = req_nodes[0] & arb_o.gnt;

    //////////////////////////////
    // lock-in
    //////////////////////////////

    if (LockIn) begin : gen_lock
      logic             lock_q;
      logic [NumIn-1:0] req_q;

      // while locked the tree keeps seeing last cycle's requests, so the winner stays put
      assign req_d = lock_q ? req_q : req_i;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          lock_q <= 1'b0;
          req_q  <= '0;
        end else if (flush_i) begin
          lock_q <= 1'b0;
          req_q  <= '0;
        end else begin
          // a request the bank did not take keeps the decision for the next cycle
          lock_q <= req_nodes[0] & ~arb_o.gnt;
          req_q  <= req_d;
        end
      end
    end else begin : gen_no_lock
      assign req_d = req_i;
    end

    //////////////////////////////
    // priority update
    //////////////////////////////

    if (FairArb) begin : gen_fair
      logic [NumIn-1:0]    upper_mask;
      logic [NumIn-1:0]    lower_mask;
      logic [IdxWidth-1:0] upper_idx;
      logic [IdxWidth-1:0] lower_idx;
      logic [IdxWidth-1:0] next_idx;
      logic                upper_empty;
      logic                lower_empty;

      // split the waiting requests around the index being served right now
      for (genvar i = 0; i < NumIn; i++) begin : gen_mask
        assign upper_mask[i] = (IdxWidth'(i) >  idx_nodes[0]) ? req_d[i] : 1'b0;
        assign lower_mask[i] = (IdxWidth'(i) <= idx_nodes[0]) ? req_d[i] : 1'b0;
      end

      // first waiting requester above the served one
      lzc #(
        .Width (NumIn),
        .Mode  (1'b0)
      ) i_lzc_upper (
        .in_i    (upper_mask),
        .cnt_o   (upper_idx),
        .empty_o (upper_empty)
      );

      // wrap around to the lowest waiting requester
      lzc #(
        .Width (NumIn),
        .Mode  (1'b0)
      ) i_lzc_lower (
        .in_i    (lower_mask),
        .cnt_o   (lower_idx),
        .empty_o (lower_empty)
      );

      always_comb begin
        if (!upper_empty) begin
          next_idx = upper_idx;
        end else if (!lower_empty) begin
          next_idx = lower_idx;
        end else begin
          next_idx = rr_q;
        end
      end

      assign rr_d = accept ? next_idx : rr_q;
    end else begin : gen_rotate
      // plain counter, blind to which inputs are waiting
      assign rr_d = !accept                     ? rr_q :
                    (rr_q == IdxWidth'(NumIn-1)) ? '0   : rr_q + 1'b1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (flush_i) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_d;
      end
    end

    //////////////////////////////
    // selector tree
    //////////////////////////////

    // the bank grant enters at the root and is steered down to the winner
    assign gnt_nodes[0] = arb_o.gnt;

    for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
      for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
        localparam int unsigned Node    = 2**level - 1 + l;
        localparam int unsigned Child   = 2**(level+1) - 1 + l*2;
        localparam int unsigned LowBits = NumLevels - level - 1;

        // high picks the right child
        logic sel;

        if (level == NumLevels-1) begin : gen_leaf
          if (l*2 < NumIn-1) begin : gen_pair
            // right wins only if it requests and the priority bit of this level points at it
            assign sel = ~req_d[l*2] | (req_d[l*2+1] & rr_q[NumLevels-1-level]);

            assign req_nodes[Node]  = req_d[l*2] | req_d[l*2+1];
            assign idx_nodes[Node]  = IdxWidth'(sel);
            assign data_nodes[Node] = sel ? data_i[l*2+1] : data_i[l*2];
            assign gnt_o[l*2]       = gnt_nodes[Node] & req_d[l*2] & ~sel;
            assign gnt_o[l*2+1]     = gnt_nodes[Node] & req_d[l*2+1] & sel;
          end else if (l*2 == NumIn-1) begin : gen_odd
            // last input of an odd count has no partner
            assign sel              = 1'b0;
            assign req_nodes[Node]  = req_d[l*2];
            assign idx_nodes[Node]  = '0;
            assign data_nodes[Node] = data_i[l*2];
            assign gnt_o[l*2]       = gnt_nodes[Node] & req_d[l*2];
          end else begin : gen_pad
            // padding leaves never request
            assign sel              = 1'b0;
            assign req_nodes[Node]  = 1'b0;
            assign idx_nodes[Node]  = '0;
            assign data_nodes[Node] = '0;
          end
        end else begin : gen_inner
          assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & rr_q[NumLevels-1-level]);

          assign req_nodes[Node]  = req_nodes[Child] | req_nodes[Child+1];
          // each level adds its own decision as the next higher index bit
          assign idx_nodes[Node]  = sel ?
            IdxWidth'({1'b1, idx_nodes[Child+1][LowBits-1:0]}) :
            IdxWidth'({1'b0, idx_nodes[Child][LowBits-1:0]});
          assign data_nodes[Node] = sel ? data_nodes[Child+1] : data_nodes[Child];
          assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
          assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
        end
      end
    end
  end

endmodule

// ==== sim.f ====
common/scratch_pkg.sv
common/mem_req_if.sv
design/lzc.sv
rr_arb_tree/rr_arb_tree.sv
design/scratch_bank.sv
design/scratch_arb_top.sv
test/tb_checker.sv
test/tb_scratch.sv

// ==== test/tb_checker.sv ====
// tb_checker: memory and priority model that compares DUT grants and read responses
module tb_checker import scratch_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic    [3:0]                 req_i,
  input  mem_op_e [3:0]                 op_i,
  input  logic    [3:0][AddrWidth-1:0]  addr_i,
  input  logic    [3:0][DataWidth-1:0]  wdata_i,
  input  logic    [3:0]                 gnt_o,
  input  logic                          rvalid_o,
  input  logic    [1:0]                 rid_o,
  input  logic    [DataWidth-1:0]       rdata_o,
  output int                            err_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DataWidth-1:0] mem [32];
  bit                   known [32];
  int                   prio;
  bit                   stall;
  bit                   lock;
  logic [3:0]           frozen;
  bit                   rd_pend;
  bit                   rd_known;
  logic [1:0]           rd_id;
  logic [DataWidth-1:0] rd_data;
  int                   order [$];
  int                   err_at_start;
  int                   tests_run;
  int                   tests_ok;

  initial begin
    err_cnt_o    = 0;
    err_at_start = 0;
    tests_run    = 0;
    tests_ok     = 0;
    foreach (known[i]) known[i] = 1'b0;
  end

  task automatic wrong_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    err_cnt_o++;
  endtask

  task automatic flag_error(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt_o++;
  endtask

  // first requester at or above the priority, wrapping around
  function automatic int first_req(input logic [3:0] r, input int p);
    for (int k = 0; k < 4; k++) begin
      if (r[(p + k) % 4]) return (p + k) % 4;
    end
    return 0;
  endfunction

  // next waiting requester above the served one, else the lowest at or below it
  function automatic int next_prio(input logic [3:0] r, input int served);
    for (int k = served + 1; k < 4; k++) begin
      if (r[k]) return k;
    end
    for (int k = 0; k <= served; k++) begin
      if (r[k]) return k;
    end
    return served;
  endfunction

  ////////////////////////////////
  // per cycle model
  ////////////////////////////////

  // inputs change on the rising edge, so mid-cycle everything is settled
  always @(negedge clk_i) begin
    logic [3:0] eff;
    logic [3:0] exp_g;
    int         w;
    if (!rst_ni) begin
      prio    = 0;
      stall   = 1'b0;
      lock    = 1'b0;
      frozen  = '0;
      rd_pend = 1'b0;
    end else begin
      if (rvalid_o !== rd_pend) begin
        wrong_value("rvalid_o", rd_pend, rvalid_o);
      end else if (rd_pend) begin
        if (rid_o !== rd_id) wrong_value("rid_o", rd_id, rid_o);
        if (rd_known && rdata_o !== rd_data) wrong_value("rdata_o", rd_data, rdata_o);
      end
      rd_pend = 1'b0;
      if (stall) begin
        // turnaround cycle, the arbiter freezes whatever is waiting now
        if (gnt_o !== 4'b0000) wrong_value("gnt_o", 4'b0000, gnt_o);
        frozen = req_i;
        lock   = (req_i != 4'b0000);
        stall  = 1'b0;
      end else begin
        eff   = lock ? frozen : req_i;
        lock  = 1'b0;
        exp_g = '0;
        w     = 0;
        if (eff != 4'b0000) begin
          w        = first_req(eff, prio);
          exp_g[w] = 1'b1;
        end
        if (gnt_o !== exp_g) begin
          wrong_value("gnt_o", exp_g, gnt_o);
        end else if (eff != 4'b0000) begin
          order.push_back(w);
          prio = next_prio(eff, w);
          if (op_i[w] == OP_WRITE) begin
            mem[addr_i[w]]   = wdata_i[w];
            known[addr_i[w]] = 1'b1;
            stall            = 1'b1;
          end else begin
            rd_pend  = 1'b1;
            rd_id    = 2'(w);
            rd_data  = mem[addr_i[w]];
            rd_known = known[addr_i[w]];
          end
        end
      end
      if (flush_i) begin
        prio   = 0;
        lock   = 1'b0;
        frozen = '0;
      end
    end
  end

  ////////////////////////////////
  // test bookkeeping
  ////////////////////////////////

  task automatic end_test(input int t, input int cnt, input logic [15:0] exp_order);
    if (order.size() != cnt) begin
      flag_error($sformatf("test %0d saw %0d grants instead of %0d", t, order.size(), cnt));
    end else begin
      for (int k = 0; k < cnt; k++) begin
        if (order[k] != exp_order[2*k +: 2]) begin
          wrong_value($sformatf("grant %0d winner", k), exp_order[2*k +: 2], order[k]);
        end
      end
    end
    tests_run++;
    if (err_cnt_o == err_at_start) begin
      tests_ok++;
      $display("test %0d: ok, %0d grants", t, cnt);
    end else begin
      $display("test %0d: FAIL, %0d errors", t, err_cnt_o - err_at_start);
    end
    err_at_start = err_cnt_o;
    order.delete();
  endtask

  task automatic report();
    $display("%0d tests run, %0d ok, %0d errors", tests_run, tests_ok, err_cnt_o);
  endtask

endmodule

// ==== test/tb_scratch.sv ====
// tb_scratch: testbench top with clock, reset, stimulus table, xorshift data, timeout and DUT
module tb_scratch import scratch_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumReq        = 4;
  localparam int unsigned NumTests      = 8;
  localparam int unsigned TimeoutCycles = NumTests * 8 + 20;

  // one table row is one test, every requester in the mask issues rounds requests
  // exp_order holds the expected winners, two bits per grant, first grant lowest
  typedef struct {
    logic [NumReq-1:0] mask;
    mem_op_e           op;
    int                rounds;
    bit                flush;
    logic [4:0]        base;
    int                stride;
    int                exp_cnt;
    logic [15:0]       exp_order;
  } test_t;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              flush_i;
  logic    [NumReq-1:0]              req_i;
  mem_op_e [NumReq-1:0]              op_i;
  logic    [NumReq-1:0][AddrWidth-1:0] addr_i;
  logic    [NumReq-1:0][DataWidth-1:0] wdata_i;
  logic    [NumReq-1:0]              gnt_o;
  logic                              rvalid_o;
  logic    [1:0]                     rid_o;
  logic    [DataWidth-1:0]           rdata_o;
  int                                err_cnt;
  test_t                             tests [NumTests];
  logic    [31:0]                    rng;
  int                                cycles;

  scratch_arb_top #(
    .NumReq  (NumReq),
    .FairArb (1'b1),
    .LockIn  (1'b1)
  ) uut (
    .clk_i, .rst_ni, .flush_i, .req_i, .op_i, .addr_i, .wdata_i,
    .gnt_o, .rvalid_o, .rid_o, .rdata_o
  );

  tb_checker chk (
    .clk_i, .rst_ni, .flush_i, .req_i, .op_i, .addr_i, .wdata_i,
    .gnt_o, .rvalid_o, .rid_o, .rdata_o, .err_cnt_o (err_cnt)
  );

  // 32-bit xorshift step for write data
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // the run cannot outlast the longest plausible table
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout after %0d cycles, a request was never granted", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    int left [NumReq];
    int busy;
    test_t cur;
    // idle, write then read back, full rounds, fair pair, write stalls, flush mid-run
    tests[0] = '{4'b0000, OP_READ,  1, 1'b0, 5'd0,  0, 0, 16'h0000};
    tests[1] = '{4'b0010, OP_WRITE, 1, 1'b1, 5'd4,  0, 1, 16'h0001};
    tests[2] = '{4'b0010, OP_READ,  1, 1'b0, 5'd4,  0, 1, 16'h0001};
    tests[3] = '{4'b1111, OP_READ,  2, 1'b1, 5'd4,  0, 8, 16'hE4E4};
    tests[4] = '{4'b0101, OP_READ,  2, 1'b1, 5'd4,  0, 4, 16'h0088};
    tests[5] = '{4'b1111, OP_WRITE, 1, 1'b0, 5'd16, 1, 4, 16'h004E};
    tests[6] = '{4'b1111, OP_READ,  1, 1'b0, 5'd16, 1, 4, 16'h0039};
    tests[7] = '{4'b1111, OP_WRITE, 1, 1'b1, 5'd24, 1, 4, 16'h00E4};
    cycles  = 0;
    rng     = 32'h810b3b30;
    rst_ni  = 1'b0;
    flush_i = 1'b0;
    req_i   = '0;
    op_i    = {NumReq{OP_READ}};
    addr_i  = '0;
    wdata_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int t = 0; t < NumTests; t++) begin
      cur = tests[t];
      @(posedge clk_i);
      if (cur.flush) begin
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
      end
      busy = 0;
      for (int i = 0; i < NumReq; i++) begin
        left[i] = cur.mask[i] ? cur.rounds : 0;
        busy += left[i];
        rng = xorshift32(rng);
        op_i[i]    <= cur.op;
        addr_i[i]  <= cur.base + AddrWidth'(i * cur.stride);
        wdata_i[i] <= rng;
        req_i[i]   <= cur.mask[i];
      end
      if (busy == 0) begin
        // nothing requested, just watch the outputs stay quiet
        repeat (4) @(posedge clk_i);
      end
      while (busy > 0) begin
        @(posedge clk_i);
        for (int i = 0; i < NumReq; i++) begin
          if (req_i[i] && gnt_o[i]) begin
            left[i]--;
            busy--;
            if (left[i] > 0) begin
              rng = xorshift32(rng);
              wdata_i[i] <= rng;
            end else begin
              req_i[i] <= 1'b0;
            end
          end
        end
      end
      // the response to the last read of this test arrives one cycle after its grant
      @(posedge clk_i);
      chk.end_test(t, cur.exp_cnt, cur.exp_order);
    end

    // let the last read response reach the checker
    repeat (3) @(posedge clk_i);
    chk.report();
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
